//--- src/glcm_pkg.sv
// shared sizes and types for the 16x16 GLCM engine
// gray levels are 5 bits and bins 8 bits; bins wrap modulo 256
`default_nettype none

package glcm_pkg;

    // --------------------
    // image geometry
    localparam int IMG_SIDE  = 16;
    localparam int PIX_COUNT = IMG_SIDE * IMG_SIDE;
    localparam int PIX_W     = 5;

    // --------------------
    // co-occurrence matrix
    localparam int GRAY_LEVELS   = 1 << PIX_W;
    localparam int BIN_W         = 8;
    localparam int BINS_PER_WORD = 4;
    localparam int BIN_WORDS     = GRAY_LEVELS * GRAY_LEVELS / BINS_PER_WORD;

    typedef logic [PIX_W-1:0]               pixel_t;
    typedef logic [$clog2(PIX_COUNT)-1:0]   pix_addr_t;
    typedef logic [BIN_W-1:0]               bin_t;
    // bin col%4 = 0 in the top byte
    typedef logic [BIN_W*BINS_PER_WORD-1:0] bin_word_t;
    typedef logic [$clog2(BIN_WORDS)-1:0]   bin_addr_t;

    // offset request: dir[1] enables the column step, dir[0] the row step
    typedef logic [1:0] dir_t;
    typedef logic [3:0] dis_t;

endpackage

`default_nettype wire

//--- src/glcm_ram.sv
// single-port synchronous RAM, read data one cycle after the address
// read returns the old contents when reading and writing one address
// contents are undefined after power-up
`timescale 1ns/1ps
`default_nettype none

module glcm_ram #(
    parameter type data_t = logic [7:0],
    parameter int  DEPTH  = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  data_t                    wdata,
    output data_t                    rdata
);

    data_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

    // writes past the end would alias when DEPTH is not a power of two
    a_addr_in_range: assert property (@(posedge clk) we |-> (int'(addr) < DEPTH))
        else $error("glcm_ram write address out of range");

endmodule

`default_nettype wire

//--- src/glcm_ctrl.sv
// top-level sequencer: idle, load with parallel clear, pair loop, drain
// in_valid is ignored outside idle
// each pair takes four cycles: ref, nbr, bin read, bin write
`timescale 1ns/1ps
`default_nettype none

module glcm_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic load_done,
    input  logic clear_done,
    input  logic pair_last,
    input  logic drain_done,
    output logic start,
    output logic loading,
    output logic clear_start,
    output logic fetch_ref,
    output logic fetch_nbr,
    output logic advance,
    output logic bin_rd,
    output logic bin_wr,
    output logic drain_start
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_REF,
        S_NBR,
        S_RD,
        S_WR,
        S_DRAIN
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   load_seen;
    logic   clear_seen;
    logic   both_ready;

    // load and clear finish in either order
    assign both_ready = (load_seen || load_done) && (clear_seen || clear_done);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= S_IDLE;
            load_seen  <= 1'b0;
            clear_seen <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (start)
            begin
                load_seen  <= 1'b0;
                clear_seen <= 1'b0;
            end
            else
            begin
                if (load_done)
                begin
                    load_seen <= 1'b1;
                end
                if (clear_done)
                begin
                    clear_seen <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // next state
    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:  if (in_valid) state_nxt = S_LOAD;
            S_LOAD:  if (both_ready) state_nxt = S_REF;
            S_REF:   state_nxt = S_NBR;
            S_NBR:   state_nxt = S_RD;
            S_RD:    state_nxt = S_WR;
            S_WR:    state_nxt = pair_last ? S_DRAIN : S_REF;
            S_DRAIN: if (drain_done) state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    // --------------------
    // outputs
    assign start       = (state == S_IDLE) && in_valid;
    assign clear_start = start;
    // stop accepting pixels once the 256th is in
    assign loading     = (state == S_LOAD) && !load_seen;
    assign fetch_ref   = (state == S_REF);
    assign fetch_nbr   = (state == S_NBR);
    assign bin_rd      = (state == S_RD);
    assign bin_wr      = (state == S_WR);
    assign advance     = (state == S_WR) && !pair_last;
    assign drain_start = (state == S_WR) && pair_last;

    // bin store builds the write word from the previous cycle's read
    a_wr_after_rd: assert property (@(posedge clk) disable iff (!rst_n)
        bin_wr |-> $past(bin_rd))
        else $error("bin write without a preceding bin read");

endmodule

`default_nettype wire

//--- src/glcm_pixel_fetch.sv
// whole-image pixel buffer plus the reference position scan
// pixels are stored in raster order, address = row*16 + col
// the scan covers only positions whose neighbour lies inside the image
`timescale 1ns/1ps
`default_nettype none

module glcm_pixel_fetch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  glcm_pkg::dir_t    in_dir,
    input  glcm_pkg::dis_t    in_dis,
    input  logic              loading,
    input  logic              pix_valid,
    input  glcm_pkg::pixel_t  pix_data,
    input  logic              fetch_ref,
    input  logic              fetch_nbr,
    input  logic              advance,
    output logic              load_done,
    output logic              pair_last,
    output glcm_pkg::pixel_t  ref_pix,
    output glcm_pkg::pixel_t  nbr_pix
);

    typedef logic [$clog2(glcm_pkg::IMG_SIDE)-1:0] coord_t;

    glcm_pkg::pix_addr_t load_cnt;
    glcm_pkg::pix_addr_t buf_addr;
    glcm_pkg::dis_t      row_off;
    glcm_pkg::dis_t      col_off;
    coord_t              ref_row;
    coord_t              ref_col;
    coord_t              row_last;
    coord_t              col_last;
    logic                buf_we;

    assign row_last = coord_t'(glcm_pkg::IMG_SIDE - 1) - row_off;
    assign col_last = coord_t'(glcm_pkg::IMG_SIDE - 1) - col_off;

    assign buf_we    = loading && pix_valid;
    assign load_done = buf_we && (load_cnt == glcm_pkg::pix_addr_t'(glcm_pkg::PIX_COUNT - 1));
    assign pair_last = (ref_row == row_last) && (ref_col == col_last);

    // --------------------
    // offsets, load counter and position scan
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            row_off  <= '0;
            col_off  <= '0;
            load_cnt <= '0;
            ref_row  <= '0;
            ref_col  <= '0;
        end
        else if (start)
        begin
            col_off  <= in_dir[1] ? in_dis : '0;
            row_off  <= in_dir[0] ? in_dis : '0;
            load_cnt <= '0;
            ref_row  <= '0;
            ref_col  <= '0;
        end
        else
        begin
            if (buf_we)
            begin
                load_cnt <= load_cnt + 1'b1;
            end
            if (advance)
            begin
                if (ref_col == col_last)
                begin
                    ref_col <= '0;
                    ref_row <= ref_row + 1'b1;
                end
                else
                begin
                    ref_col <= ref_col + 1'b1;
                end
            end
        end
    end

    // neighbour address is held after fetch_nbr so nbr_pix stays stable
    always_comb
    begin
        if (loading)
            buf_addr = load_cnt;
        else if (fetch_ref)
            buf_addr = {ref_row, ref_col};
        else
            buf_addr = {coord_t'(ref_row + row_off), coord_t'(ref_col + col_off)};
    end

    // buffer output holds the reference pixel during fetch_nbr
    always_ff @(posedge clk)
    begin
        if (fetch_nbr)
        begin
            ref_pix <= nbr_pix;
        end
    end

    glcm_ram #(
        .data_t (glcm_pkg::pixel_t),
        .DEPTH  (glcm_pkg::PIX_COUNT)
    ) i_pix_ram (
        .clk   (clk),
        .we    (buf_we),
        .addr  (buf_addr),
        .wdata (pix_data),
        .rdata (nbr_pix)
    );

endmodule

`default_nettype wire

//--- src/glcm_bin_store.sv
// bin memory: 256 words of four packed 8-bit bins
// word = ref*8 + nbr/4, bin nbr%4 = 0 in bits 31:24
// clear and readout each sweep all 256 words, one per cycle
`timescale 1ns/1ps
`default_nettype none

module glcm_bin_store (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear_start,
    input  logic                bin_rd,
    input  logic                bin_wr,
    input  logic                drain_start,
    input  glcm_pkg::pixel_t    ref_pix,
    input  glcm_pkg::pixel_t    nbr_pix,
    output logic                clear_done,
    output logic                drain_done,
    output logic                out_valid,
    output glcm_pkg::bin_word_t out_data
);

    typedef logic [$clog2(glcm_pkg::BINS_PER_WORD)-1:0] sel_t;

    glcm_pkg::bin_addr_t clear_addr;
    glcm_pkg::bin_addr_t drain_addr;
    glcm_pkg::bin_addr_t ram_addr;
    glcm_pkg::bin_word_t ram_wdata;
    glcm_pkg::bin_word_t inc_word;
    logic                clear_active;
    logic                drain_active;
    logic                ram_we;
    sel_t                sel_q;

    assign clear_done = clear_active && (clear_addr == glcm_pkg::bin_addr_t'(glcm_pkg::BIN_WORDS - 1));

    // --------------------
    // clear and readout sweeps
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clear_active <= 1'b0;
            clear_addr   <= '0;
            drain_active <= 1'b0;
            drain_addr   <= '0;
            out_valid    <= 1'b0;
            drain_done   <= 1'b0;
        end
        else
        begin
            if (clear_start)
            begin
                clear_active <= 1'b1;
                clear_addr   <= '0;
            end
            else if (clear_active)
            begin
                clear_addr <= clear_addr + 1'b1;
                if (clear_done)
                    clear_active <= 1'b0;
            end

            if (drain_start)
            begin
                drain_active <= 1'b1;
                drain_addr   <= '0;
            end
            else if (drain_active)
            begin
                drain_addr <= drain_addr + 1'b1;
                if (drain_addr == glcm_pkg::bin_addr_t'(glcm_pkg::BIN_WORDS - 1))
                    drain_active <= 1'b0;
            end

            // aligned with the registered RAM output
            out_valid  <= drain_active;
            drain_done <= drain_active
                && (drain_addr == glcm_pkg::bin_addr_t'(glcm_pkg::BIN_WORDS - 1));
        end
    end

    // bin position within the word, kept for the write cycle
    always_ff @(posedge clk)
    begin
        if (bin_rd)
        begin
            sel_q <= nbr_pix[$bits(sel_t)-1:0];
        end
    end

    // --------------------
    // read-modify-write
    always_comb
    begin
        glcm_pkg::bin_t cur;
        inc_word = out_data;
        cur = out_data[(glcm_pkg::BINS_PER_WORD - 1 - int'(sel_q)) * glcm_pkg::BIN_W +: glcm_pkg::BIN_W];
        inc_word[(glcm_pkg::BINS_PER_WORD - 1 - int'(sel_q)) * glcm_pkg::BIN_W +: glcm_pkg::BIN_W] =
            cur + 1'b1;
    end

    always_comb
    begin
        if (clear_active)
            ram_addr = clear_addr;
        else if (drain_active)
            ram_addr = drain_addr;
        else
            ram_addr = {ref_pix, nbr_pix[glcm_pkg::PIX_W-1:$bits(sel_t)]};
    end

    assign ram_we    = clear_active || bin_wr;
    assign ram_wdata = clear_active ? '0 : inc_word;

    glcm_ram #(
        .data_t (glcm_pkg::bin_word_t),
        .DEPTH  (glcm_pkg::BIN_WORDS)
    ) i_bin_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (out_data)
    );

    a_clear_drain_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(clear_active && drain_active))
        else $error("bin clear and readout overlap");

endmodule

`default_nettype wire

//--- src/glcm_top.sv
// GLCM engine for a 16x16 image of 5-bit pixels
// no back-pressure: pixels arrive on pix_valid, readout runs 256 cycles
// in_valid is only taken while idle
`timescale 1ns/1ps
`default_nettype none

module glcm_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  glcm_pkg::dir_t      in_dir,
    input  glcm_pkg::dis_t      in_dis,
    input  logic                pix_valid,
    input  glcm_pkg::pixel_t    pix_data,
    output logic                out_valid,
    output glcm_pkg::bin_word_t out_data
);

    logic             start;
    logic             loading;
    logic             clear_start;
    logic             fetch_ref;
    logic             fetch_nbr;
    logic             advance;
    logic             bin_rd;
    logic             bin_wr;
    logic             drain_start;
    logic             load_done;
    logic             clear_done;
    logic             pair_last;
    logic             drain_done;
    glcm_pkg::pixel_t ref_pix;
    glcm_pkg::pixel_t nbr_pix;

    glcm_ctrl i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .load_done   (load_done),
        .clear_done  (clear_done),
        .pair_last   (pair_last),
        .drain_done  (drain_done),
        .start       (start),
        .loading     (loading),
        .clear_start (clear_start),
        .fetch_ref   (fetch_ref),
        .fetch_nbr   (fetch_nbr),
        .advance     (advance),
        .bin_rd      (bin_rd),
        .bin_wr      (bin_wr),
        .drain_start (drain_start)
    );

    glcm_pixel_fetch i_pixel_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .in_dir    (in_dir),
        .in_dis    (in_dis),
        .loading   (loading),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .fetch_ref (fetch_ref),
        .fetch_nbr (fetch_nbr),
        .advance   (advance),
        .load_done (load_done),
        .pair_last (pair_last),
        .ref_pix   (ref_pix),
        .nbr_pix   (nbr_pix)
    );

    glcm_bin_store i_bin_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_start (clear_start),
        .bin_rd      (bin_rd),
        .bin_wr      (bin_wr),
        .drain_start (drain_start),
        .ref_pix     (ref_pix),
        .nbr_pix     (nbr_pix),
        .clear_done  (clear_done),
        .drain_done  (drain_done),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

//--- dv/glcm_tb.sv
// random-stimulus testbench for glcm_top with a GLCM reference model
// inputs change on the falling edge and outputs are sampled there too
// image data and offsets come from $random with a fixed seed
`timescale 1ns/1ps
`default_nettype none

module glcm_tb;

    localparam int WAIT_LIMIT = 20000;
    localparam int LEN_LIMIT  = 300;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    glcm_pkg::dir_t      in_dir;
    glcm_pkg::dis_t      in_dis;
    logic                pix_valid;
    glcm_pkg::pixel_t    pix_data;
    logic                out_valid;
    glcm_pkg::bin_word_t out_data;

    integer              seed;
    int                  run;
    glcm_pkg::pixel_t    img [glcm_pkg::PIX_COUNT];
    glcm_pkg::bin_word_t model [glcm_pkg::BIN_WORDS];

    glcm_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_dir    (in_dir),
        .in_dis    (in_dis),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #5 clk = ~clk;

    // --------------------
    // failure handling and compares
    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input glcm_pkg::bin_word_t got, input glcm_pkg::bin_word_t exp,
                              input int idx);
        if (got !== exp)
        begin
            $display("error at %0t: word %0d is %08h, expected %08h", $time, idx, got, exp);
            stop_run();
        end
    endtask

    task automatic check_len(input int got, input int exp);
        if (got != exp)
        begin
            $display("error at %0t: out_valid lasted %0d cycles, expected %0d",
                     $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic fill_random();
        int p;
        for (p = 0; p < glcm_pkg::PIX_COUNT; p++)
            img[p] = glcm_pkg::pixel_t'(rand_below(glcm_pkg::GRAY_LEVELS));
    endtask

    task automatic fill_constant(input glcm_pkg::pixel_t value);
        int p;
        for (p = 0; p < glcm_pkg::PIX_COUNT; p++)
            img[p] = value;
    endtask

    // --------------------
    // reference model: count pairs, then pack 4 bins per word
    task automatic build_model(input int row_off, input int col_off);
        int w;
        int r;
        int c;
        int ref_v;
        int nbr_v;
        int word;
        int shift;
        glcm_pkg::bin_t cnt;
        for (w = 0; w < glcm_pkg::BIN_WORDS; w++)
            model[w] = '0;
        for (r = 0; r + row_off < glcm_pkg::IMG_SIDE; r++)
        begin
            for (c = 0; c + col_off < glcm_pkg::IMG_SIDE; c++)
            begin
                ref_v = int'(img[r * glcm_pkg::IMG_SIDE + c]);
                nbr_v = int'(img[(r + row_off) * glcm_pkg::IMG_SIDE + c + col_off]);
                word  = ref_v * 8 + nbr_v / 4;
                // nbr%4 = 0 lands in the top byte
                shift = (3 - nbr_v % 4) * 8;
                cnt   = glcm_pkg::bin_t'(model[word] >> shift) + 8'd1;
                model[word] = (model[word] & ~(32'hff << shift))
                    | (glcm_pkg::bin_word_t'(cnt) << shift);
            end
        end
    endtask

    // one full run: start, load img, then read back and compare
    task automatic run_once(input glcm_pkg::dir_t dir, input glcm_pkg::dis_t dis,
                            input logic inject);
        int row_off;
        int col_off;
        int p;
        int g;
        int gap;
        int cycles;
        int len;
        col_off = dir[1] ? int'(dis) : 0;
        row_off = dir[0] ? int'(dis) : 0;
        build_model(row_off, col_off);

        in_valid = 1'b1;
        in_dir   = dir;
        in_dis   = dis;
        @(negedge clk);
        in_valid = 1'b0;

        for (p = 0; p < glcm_pkg::PIX_COUNT; p++)
        begin
            gap = rand_below(4);
            for (g = 0; g < gap; g++)
            begin
                check_flag(out_valid, 1'b0, "out_valid during load");
                @(negedge clk);
            end
            pix_valid = 1'b1;
            pix_data  = img[p];
            // stray start in the middle of the load
            if (inject && p == 100)
            begin
                in_valid = 1'b1;
                in_dir   = glcm_pkg::dir_t'(rand_below(4));
                in_dis   = glcm_pkg::dis_t'(rand_below(16));
            end
            @(negedge clk);
            pix_valid = 1'b0;
            in_valid  = 1'b0;
            check_flag(out_valid, 1'b0, "out_valid during load");
        end

        // stray start while pairs are being counted
        if (inject)
        begin
            @(negedge clk);
            in_valid = 1'b1;
            in_dir   = glcm_pkg::dir_t'(rand_below(4));
            in_dis   = glcm_pkg::dis_t'(rand_below(16));
            @(negedge clk);
            in_valid = 1'b0;
        end

        cycles = 0;
        while (out_valid !== 1'b1 && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (out_valid !== 1'b1)
        begin
            $display("timeout: out_valid never rose within %0d cycles", WAIT_LIMIT);
            stop_run();
        end

        len = 0;
        while (out_valid === 1'b1 && len < LEN_LIMIT)
        begin
            if (len < glcm_pkg::BIN_WORDS)
                check_word(out_data, model[len], len);
            len++;
            @(negedge clk);
        end
        check_len(len, glcm_pkg::BIN_WORDS);
    endtask

    // --------------------
    // main sequence
    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_dir    = '0;
        in_dis    = '0;
        pix_valid = 1'b0;
        pix_data  = '0;
        seed      = 54;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag(out_valid, 1'b0, "out_valid after reset");

        // odd runs also get stray in_valid pulses
        for (run = 0; run < 8; run++)
        begin
            fill_random();
            run_once(glcm_pkg::dir_t'(rand_below(4)), glcm_pkg::dis_t'(rand_below(16)),
                     run[0]);
        end

        // zero offset on a flat image: 256 counts in one bin wrap to 0
        fill_constant(glcm_pkg::pixel_t'(rand_below(glcm_pkg::GRAY_LEVELS)));
        run_once(2'd0, glcm_pkg::dis_t'(rand_below(16)), 1'b0);

        // corner to corner, a single pair
        fill_random();
        run_once(2'd3, 4'd15, 1'b0);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- glcm_top.f
src/glcm_pkg.sv
src/glcm_ram.sv
src/glcm_ctrl.sv
src/glcm_pixel_fetch.sv
src/glcm_bin_store.sv
src/glcm_top.sv
dv/glcm_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module glcm_tb -f glcm_top.f -o glcm_sim

sim_out=$(./obj_dir/glcm_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
